//--- logic/router_pkg.sv
package router_pkg;

    // ============================================================
    // Bus widths and address map
    // ============================================================
    localparam int ADDR_W      = 8;
    localparam int DATA_W      = 32;
    localparam int ID_W        = 2;
    localparam int LEN_W       = 8;
    localparam int SIZE_W      = 3;
    localparam int BURST_W     = 2;
    localparam int RESP_W      = 2;

    localparam int NUM_SLAVES  = 2;
    localparam int REGION_BITS = 2;
    // Last port is the decode-error responder
    localparam int NUM_PORTS   = NUM_SLAVES + 1;

    localparam int FIFO_DEPTH  = 8;
    localparam int FIFO_PTR_W  = $clog2(FIFO_DEPTH);
    localparam int FIFO_CNT_W  = $clog2(FIFO_DEPTH + 1);

    localparam logic [RESP_W-1:0] RESP_OKAY   = 2'b00;
    localparam logic [RESP_W-1:0] RESP_DECERR = 2'b11;

    // AR word layout, address at bit 0
    localparam int AR_ADDR_LSB  = 0;
    localparam int AR_BURST_LSB = AR_ADDR_LSB + ADDR_W;
    localparam int AR_SIZE_LSB  = AR_BURST_LSB + BURST_W;
    localparam int AR_LEN_LSB   = AR_SIZE_LSB + SIZE_W;
    localparam int AR_ID_LSB    = AR_LEN_LSB + LEN_W;
    localparam int AR_W         = AR_ID_LSB + ID_W;

    // R beat layout, last at bit 0
    localparam int R_LAST_BIT   = 0;
    localparam int R_RESP_LSB   = R_LAST_BIT + 1;
    localparam int R_DATA_LSB   = R_RESP_LSB + RESP_W;
    localparam int R_ID_LSB     = R_DATA_LSB + DATA_W;
    localparam int R_W          = R_ID_LSB + ID_W;

    // ============================================================
    // Types
    // ============================================================
    typedef logic [ADDR_W-1:0]      addr_t;
    typedef logic [DATA_W-1:0]      data_t;
    typedef logic [ID_W-1:0]        id_t;
    typedef logic [LEN_W-1:0]       len_t;
    typedef logic [SIZE_W-1:0]      size_t;
    typedef logic [BURST_W-1:0]     burst_t;
    typedef logic [RESP_W-1:0]      resp_t;
    typedef logic [REGION_BITS-1:0] region_t;

    typedef logic [AR_W-1:0]        ar_chan_t;
    typedef logic [R_W-1:0]         r_chan_t;
    typedef logic [NUM_PORTS-1:0]   port_sel_t;

    typedef enum logic [1:0] {RT_IDLE, RT_ADDR, RT_DATA} route_state_t;
    typedef enum logic {DE_IDLE, DE_RESP} decerr_state_t;

endpackage

//--- logic/ar_fifo.sv
`timescale 1ns/1ps

module ar_fifo (
    input  logic                 ACLK,
    input  logic                 ARESETN,
    input  logic                 wr_valid_i,
    output logic                 wr_ready_o,
    input  router_pkg::ar_chan_t wr_data_i,
    output logic                 rd_valid_o,
    input  logic                 rd_ready_i,
    output router_pkg::ar_chan_t rd_data_o
);
    import router_pkg::*;

    ar_chan_t              mem [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] wr_ptr;
    logic [FIFO_PTR_W-1:0] rd_ptr;
    logic [FIFO_CNT_W-1:0] count;
    logic                  out_free;
    logic                  push;
    logic                  load_buf;
    logic                  bypass;
    logic                  buf_wr;

    function automatic logic [FIFO_PTR_W-1:0] next_ptr(input logic [FIFO_PTR_W-1:0] ptr);
        if (ptr == FIFO_PTR_W'(FIFO_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign wr_ready_o = (count != FIFO_CNT_W'(FIFO_DEPTH));
    assign push       = wr_valid_i && wr_ready_o;
    // Output register can take a new word this cycle
    assign out_free   = !rd_valid_o || rd_ready_i;
    assign load_buf   = out_free && (count != '0);
    // Empty buffer, so the word goes straight to the head register
    assign bypass     = out_free && (count == '0) && push;
    assign buf_wr     = push && !bypass;

    always_ff @(posedge ACLK or negedge ARESETN) begin
        if (!ARESETN) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            rd_valid_o <= 1'b0;
        end else begin
            if (buf_wr) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (load_buf) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({buf_wr, load_buf})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            if (load_buf || bypass) begin
                rd_valid_o <= 1'b1;
            end else if (rd_ready_i) begin
                rd_valid_o <= 1'b0;
            end
        end
    end

    // Storage and head payload
    always_ff @(posedge ACLK) begin
        if (buf_wr) begin
            mem[wr_ptr] <= wr_data_i;
        end
        if (load_buf) begin
            rd_data_o <= mem[rd_ptr];
        end else if (bypass) begin
            rd_data_o <= wr_data_i;
        end
    end

endmodule

//--- logic/rd_route_ctrl.sv
`timescale 1ns/1ps

module rd_route_ctrl (
    input  logic                  ACLK,
    input  logic                  ARESETN,
    input  logic                  head_valid_i,
    input  router_pkg::ar_chan_t  head_data_i,
    input  logic                  head_pop_i,
    input  logic                  r_last_done_i,
    output router_pkg::port_sel_t ar_sel_o,
    output router_pkg::port_sel_t r_sel_o
);
    import router_pkg::*;

    route_state_t state;
    port_sel_t    sel_q;
    port_sel_t    dec_sel;
    region_t      region;

    // Region taken from the top address bits
    assign region = head_data_i[AR_ADDR_LSB + ADDR_W - 1 -: REGION_BITS];

    always_comb begin
        dec_sel = '0;
        if (region < NUM_SLAVES) begin
            dec_sel[region] = 1'b1;
        end else begin
            // Unmapped, send to the error responder
            dec_sel[NUM_PORTS-1] = 1'b1;
        end
    end

    always_ff @(posedge ACLK or negedge ARESETN) begin
        if (!ARESETN) begin
            state <= RT_IDLE;
            sel_q <= '0;
        end else begin
            case (state)
                RT_IDLE: begin
                    if (head_valid_i) begin
                        sel_q <= dec_sel;
                        state <= RT_ADDR;
                    end
                end
                RT_ADDR: begin
                    if (head_pop_i) begin
                        state <= RT_DATA;
                    end
                end
                RT_DATA: begin
                    if (r_last_done_i) begin
                        state <= RT_IDLE;
                        sel_q <= '0;
                    end
                end
                default: begin
                    state <= RT_IDLE;
                end
            endcase
        end
    end

    // Address path open only until the head is taken
    assign ar_sel_o = (state == RT_ADDR) ? sel_q : '0;
    assign r_sel_o  = (state != RT_IDLE) ? sel_q : '0;

endmodule

//--- logic/ar_demux.sv
`timescale 1ns/1ps

module ar_demux (
    input  router_pkg::port_sel_t                  sel_i,
    input  logic                                   s_valid_i,
    output logic                                   s_ready_o,
    input  router_pkg::ar_chan_t                   s_data_i,
    output logic [router_pkg::NUM_PORTS-1:0]       m_valid_o,
    input  logic [router_pkg::NUM_PORTS-1:0]       m_ready_i,
    output router_pkg::ar_chan_t                   m_data_o [router_pkg::NUM_PORTS]
);
    import router_pkg::*;

    // Valid goes to the selected port only
    assign m_valid_o = sel_i & {NUM_PORTS{s_valid_i}};

    // No selection gives ready low
    assign s_ready_o = |(sel_i & m_ready_i);

    // Same word offered on every port
    always_comb begin
        for (int i = 0; i < NUM_PORTS; i++) begin
            m_data_o[i] = s_data_i;
        end
    end

endmodule

//--- logic/r_mux.sv
`timescale 1ns/1ps

module r_mux (
    input  router_pkg::port_sel_t            sel_i,
    input  logic [router_pkg::NUM_PORTS-1:0] s_valid_i,
    output logic [router_pkg::NUM_PORTS-1:0] s_ready_o,
    input  router_pkg::r_chan_t              s_data_i [router_pkg::NUM_PORTS],
    output logic                             m_valid_o,
    input  logic                             m_ready_i,
    output router_pkg::r_chan_t              m_data_o
);
    import router_pkg::*;

    // Beat from the selected port, idle otherwise
    always_comb begin
        m_valid_o = 1'b0;
        m_data_o  = '0;
        for (int i = 0; i < NUM_PORTS; i++) begin
            if (sel_i[i]) begin
                m_valid_o = s_valid_i[i];
                m_data_o  = s_data_i[i];
            end
        end
    end

    // Master ready returned to the selected port only
    assign s_ready_o = sel_i & {NUM_PORTS{m_ready_i}};

endmodule

//--- logic/rd_decerr_slave.sv
`timescale 1ns/1ps

module rd_decerr_slave (
    input  logic                 ACLK,
    input  logic                 ARESETN,
    input  logic                 ar_valid_i,
    output logic                 ar_ready_o,
    input  router_pkg::ar_chan_t ar_data_i,
    output logic                 r_valid_o,
    input  logic                 r_ready_i,
    output router_pkg::r_chan_t  r_data_o
);
    import router_pkg::*;

    decerr_state_t state;
    id_t           id_q;
    len_t          len_q;
    len_t          beat_cnt;
    logic          last_beat;

    assign ar_ready_o = (state == DE_IDLE);
    assign r_valid_o  = (state == DE_RESP);
    assign last_beat  = (beat_cnt == len_q);

    // Zero data, decode error, last on the final beat
    assign r_data_o = {id_q, {DATA_W{1'b0}}, RESP_DECERR, last_beat};

    always_ff @(posedge ACLK or negedge ARESETN) begin
        if (!ARESETN) begin
            state    <= DE_IDLE;
            beat_cnt <= '0;
        end else begin
            case (state)
                DE_IDLE: begin
                    if (ar_valid_i) begin
                        beat_cnt <= '0;
                        state    <= DE_RESP;
                    end
                end
                DE_RESP: begin
                    if (r_ready_i) begin
                        if (last_beat) begin
                            state <= DE_IDLE;
                        end else begin
                            beat_cnt <= beat_cnt + 1'b1;
                        end
                    end
                end
                default: begin
                    state <= DE_IDLE;
                end
            endcase
        end
    end

    // Captured request fields
    always_ff @(posedge ACLK) begin
        if (ar_valid_i && ar_ready_o) begin
            id_q  <= ar_data_i[AR_ID_LSB +: ID_W];
            len_q <= ar_data_i[AR_LEN_LSB +: LEN_W];
        end
    end

endmodule

//--- logic/axi_rd_router.sv
`timescale 1ns/1ps

module axi_rd_router (
    input  logic                              ACLK,
    input  logic                              ARESETN,
    // ============================================================
    // Master read address channel
    // ============================================================
    input  router_pkg::id_t                   s_axi_arid_i,
    input  router_pkg::addr_t                 s_axi_araddr_i,
    input  router_pkg::len_t                  s_axi_arlen_i,
    input  router_pkg::size_t                 s_axi_arsize_i,
    input  router_pkg::burst_t                s_axi_arburst_i,
    input  logic                              s_axi_arvalid_i,
    output logic                              s_axi_arready_o,
    // ============================================================
    // Master read data channel
    // ============================================================
    output router_pkg::id_t                   s_axi_rid_o,
    output router_pkg::data_t                 s_axi_rdata_o,
    output router_pkg::resp_t                 s_axi_rresp_o,
    output logic                              s_axi_rlast_o,
    output logic                              s_axi_rvalid_o,
    input  logic                              s_axi_rready_i,
    // ============================================================
    // Downstream read ports
    // ============================================================
    output router_pkg::ar_chan_t              m_ar_data_o [router_pkg::NUM_SLAVES],
    output logic [router_pkg::NUM_SLAVES-1:0] m_ar_valid_o,
    input  logic [router_pkg::NUM_SLAVES-1:0] m_ar_ready_i,
    input  router_pkg::r_chan_t               m_r_data_i [router_pkg::NUM_SLAVES],
    input  logic [router_pkg::NUM_SLAVES-1:0] m_r_valid_i,
    output logic [router_pkg::NUM_SLAVES-1:0] m_r_ready_o
);
    import router_pkg::*;

    ar_chan_t  ar_word;
    ar_chan_t  head_data;
    logic      head_valid;
    logic      head_ready;
    logic      head_pop;
    logic      r_last_done;
    port_sel_t ar_sel;
    port_sel_t r_sel;
    r_chan_t   r_beat;

    // Per-port channels, error responder on the top index
    wire [NUM_PORTS-1:0] ar_valid;
    wire [NUM_PORTS-1:0] ar_ready;
    wire [NUM_PORTS-1:0] r_valid;
    wire [NUM_PORTS-1:0] r_ready;
    wire ar_chan_t       ar_data [NUM_PORTS];
    wire r_chan_t        r_data [NUM_PORTS];

    assign ar_word = {s_axi_arid_i, s_axi_arlen_i, s_axi_arsize_i,
                      s_axi_arburst_i, s_axi_araddr_i};

    assign head_pop    = head_valid && head_ready;
    assign r_last_done = s_axi_rvalid_o && s_axi_rready_i && s_axi_rlast_o;

    assign s_axi_rid_o   = r_beat[R_ID_LSB +: ID_W];
    assign s_axi_rdata_o = r_beat[R_DATA_LSB +: DATA_W];
    assign s_axi_rresp_o = r_beat[R_RESP_LSB +: RESP_W];
    assign s_axi_rlast_o = r_beat[R_LAST_BIT];

    assign m_ar_valid_o              = ar_valid[NUM_SLAVES-1:0];
    assign ar_ready[NUM_SLAVES-1:0]  = m_ar_ready_i;
    assign r_valid[NUM_SLAVES-1:0]   = m_r_valid_i;
    assign m_r_ready_o               = r_ready[NUM_SLAVES-1:0];

    for (genvar i = 0; i < NUM_SLAVES; i++) begin : g_port
        assign m_ar_data_o[i] = ar_data[i];
        assign r_data[i]      = m_r_data_i[i];
    end

    ar_fifo ar_fifo_inst (
        .ACLK      (ACLK),
        .ARESETN   (ARESETN),
        .wr_valid_i(s_axi_arvalid_i),
        .wr_ready_o(s_axi_arready_o),
        .wr_data_i (ar_word),
        .rd_valid_o(head_valid),
        .rd_ready_i(head_ready),
        .rd_data_o (head_data)
    );

    rd_route_ctrl rd_route_ctrl_inst (
        .ACLK         (ACLK),
        .ARESETN      (ARESETN),
        .head_valid_i (head_valid),
        .head_data_i  (head_data),
        .head_pop_i   (head_pop),
        .r_last_done_i(r_last_done),
        .ar_sel_o     (ar_sel),
        .r_sel_o      (r_sel)
    );

    ar_demux ar_demux_inst (
        .sel_i    (ar_sel),
        .s_valid_i(head_valid),
        .s_ready_o(head_ready),
        .s_data_i (head_data),
        .m_valid_o(ar_valid),
        .m_ready_i(ar_ready),
        .m_data_o (ar_data)
    );

    r_mux r_mux_inst (
        .sel_i    (r_sel),
        .s_valid_i(r_valid),
        .s_ready_o(r_ready),
        .s_data_i (r_data),
        .m_valid_o(s_axi_rvalid_o),
        .m_ready_i(s_axi_rready_i),
        .m_data_o (r_beat)
    );

    rd_decerr_slave rd_decerr_slave_inst (
        .ACLK      (ACLK),
        .ARESETN   (ARESETN),
        .ar_valid_i(ar_valid[NUM_PORTS-1]),
        .ar_ready_o(ar_ready[NUM_PORTS-1]),
        .ar_data_i (ar_data[NUM_PORTS-1]),
        .r_valid_o (r_valid[NUM_PORTS-1]),
        .r_ready_i (r_ready[NUM_PORTS-1]),
        .r_data_o  (r_data[NUM_PORTS-1])
    );

endmodule

//--- sim/rd_slave_model.sv
`timescale 1ns/1ps

module rd_slave_model #(
    parameter int PORT_IDX = 0
) (
    input  logic                 ACLK,
    input  logic                 ARESETN,
    input  logic                 ar_valid_i,
    output logic                 ar_ready_o,
    input  router_pkg::ar_chan_t ar_data_i,
    output logic                 r_valid_o,
    input  logic                 r_ready_i,
    output router_pkg::r_chan_t  r_data_o
);
    import router_pkg::*;

    id_t   id_q;
    addr_t addr_q;
    len_t  len_q;
    int    gap;

    initial begin
        ar_ready_o = 1'b0;
        r_valid_o  = 1'b0;
        r_data_o   = '0;
        forever begin
            // Address phase, ready comes and goes at random
            do begin
                @(posedge ACLK);
                #1;
                r_valid_o  = 1'b0;
                ar_ready_o = ARESETN && ($urandom_range(0, 3) != 0);
                @(negedge ACLK);
            end while (!(ar_valid_i && ar_ready_o));
            id_q   = ar_data_i[AR_ID_LSB +: ID_W];
            addr_q = ar_data_i[AR_ADDR_LSB +: ADDR_W];
            len_q  = ar_data_i[AR_LEN_LSB +: LEN_W];
            for (int i = 0; i <= int'(len_q); i++) begin
                @(posedge ACLK);
                #1;
                ar_ready_o = 1'b0;
                r_valid_o  = 1'b0;
                gap = $urandom_range(0, 2);
                while (gap > 0) begin
                    @(posedge ACLK);
                    #1;
                    gap--;
                end
                // Port index, zero byte, address, beat number
                r_data_o  = {id_q, 8'(PORT_IDX), 8'h00, addr_q, 8'(i), RESP_OKAY,
                             (i == int'(len_q))};
                r_valid_o = 1'b1;
                @(negedge ACLK);
                while (!r_ready_i) begin
                    @(negedge ACLK);
                end
            end
        end
    end

endmodule

//--- sim/tb_axi_rd_router.sv
`timescale 1ns/1ps

module tb_axi_rd_router;
    import router_pkg::*;

    localparam int TIMEOUT_CYCLES = 2000;

    logic                  ACLK;
    logic                  ARESETN;
    id_t                   arid;
    addr_t                 araddr;
    len_t                  arlen;
    size_t                 arsize;
    burst_t                arburst;
    logic                  arvalid;
    logic                  arready;
    id_t                   rid;
    data_t                 rdata;
    resp_t                 rresp;
    logic                  rlast;
    logic                  rvalid;
    logic                  rready;
    ar_chan_t              m_ar_data [NUM_SLAVES];
    logic [NUM_SLAVES-1:0] m_ar_valid;
    logic [NUM_SLAVES-1:0] m_ar_ready;
    r_chan_t               m_r_data [NUM_SLAVES];
    logic [NUM_SLAVES-1:0] m_r_valid;
    logic [NUM_SLAVES-1:0] m_r_ready;

    // Expected beats in issue order
    data_t exp_data_q [$];
    resp_t exp_resp_q [$];
    id_t   exp_id_q [$];
    logic  exp_last_q [$];
    string exp_name_q [$];
    logic  throttle_rready;
    logic  unmapped_phase;

    initial begin
        ACLK = 1'b0;
        forever #2 ACLK = ~ACLK;
    end

    axi_rd_router axi_rd_router_inst (
        .ACLK(ACLK), .ARESETN(ARESETN),
        .s_axi_arid_i(arid), .s_axi_araddr_i(araddr), .s_axi_arlen_i(arlen),
        .s_axi_arsize_i(arsize), .s_axi_arburst_i(arburst),
        .s_axi_arvalid_i(arvalid), .s_axi_arready_o(arready),
        .s_axi_rid_o(rid), .s_axi_rdata_o(rdata), .s_axi_rresp_o(rresp),
        .s_axi_rlast_o(rlast), .s_axi_rvalid_o(rvalid), .s_axi_rready_i(rready),
        .m_ar_data_o(m_ar_data), .m_ar_valid_o(m_ar_valid), .m_ar_ready_i(m_ar_ready),
        .m_r_data_i(m_r_data), .m_r_valid_i(m_r_valid), .m_r_ready_o(m_r_ready)
    );

    for (genvar p = 0; p < NUM_SLAVES; p++) begin : g_slave
        rd_slave_model #(.PORT_IDX(p)) rd_slave_model_inst (
            .ACLK(ACLK), .ARESETN(ARESETN),
            .ar_valid_i(m_ar_valid[p]), .ar_ready_o(m_ar_ready[p]), .ar_data_i(m_ar_data[p]),
            .r_valid_o(m_r_valid[p]), .r_ready_i(m_r_ready[p]), .r_data_o(m_r_data[p])
        );
    end

    // ============================================================
    // Error stop, reference model and compare tasks
    // ============================================================
    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("test failed");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_data(input string name, input data_t exp, input data_t act);
        if (act !== exp) begin
            stop_run($sformatf("FAIL %s data: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_resp(input string name, input resp_t exp, input resp_t act);
        if (act !== exp) begin
            stop_run($sformatf("FAIL %s resp: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_id(input string name, input id_t exp, input id_t act);
        if (act !== exp) begin
            stop_run($sformatf("FAIL %s id: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_last(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            stop_run($sformatf("FAIL %s last: expected %b, actual %b", name, exp, act));
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            stop_run($sformatf("FAIL %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    // Mapped regions echo the slave pattern and the rest answer with a decode error
    function automatic void ref_beat(input addr_t addr, input id_t id, input len_t len,
                                     input int beat, output data_t data, output resp_t resp,
                                     output id_t exp_id, output logic last);
        int region;
        region = int'(addr[ADDR_W-1 -: REGION_BITS]);
        if (region < NUM_SLAVES) begin
            data = {8'(region), 8'h00, addr, 8'(beat)};
            resp = RESP_OKAY;
        end else begin
            data = '0;
            resp = RESP_DECERR;
        end
        exp_id = id;
        last   = (beat == int'(len));
    endfunction

    function automatic addr_t make_addr(input int region);
        return {REGION_BITS'(region), (ADDR_W-REGION_BITS)'($urandom)};
    endfunction

    // Starts just after a rising edge and ends just after the edge that took the address
    task automatic issue_read(input string name, input addr_t addr, input len_t len);
        data_t d;
        resp_t r;
        id_t   id;
        id_t   e_id;
        logic  l;
        int    cycles;
        id = id_t'($urandom);
        for (int b = 0; b <= int'(len); b++) begin
            ref_beat(addr, id, len, b, d, r, e_id, l);
            exp_data_q.push_back(d);
            exp_resp_q.push_back(r);
            exp_id_q.push_back(e_id);
            exp_last_q.push_back(l);
            exp_name_q.push_back($sformatf("%s beat %0d", name, b));
        end
        araddr  = addr;
        arid    = id;
        arlen   = len;
        arsize  = 3'd2;
        arburst = 2'b01;
        arvalid = 1'b1;
        cycles  = 0;
        @(negedge ACLK);
        while (!arready) begin
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                stop_run("Timeout: the router never accepted a read address");
            end
            @(negedge ACLK);
        end
        @(posedge ACLK);
        #1;
        arvalid = 1'b0;
    endtask

    task automatic wait_drained();
        int cycles;
        cycles = 0;
        while (exp_data_q.size() != 0) begin
            @(posedge ACLK);
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                stop_run("Timeout: read data did not complete");
            end
        end
        @(posedge ACLK);
        #1;
    endtask

    // ============================================================
    // Ready driver, monitors and compare process
    // ============================================================
    initial begin
        forever begin
            @(posedge ACLK);
            #1;
            rready = throttle_rready ? 1'($urandom_range(0, 1)) : 1'b1;
        end
    end

    always @(negedge ACLK) begin
        if (unmapped_phase && (m_ar_valid != '0)) begin
            stop_run("A slave address valid rose during an unmapped read");
        end
    end

    always @(negedge ACLK) begin : compare_beats
        string name;
        if (ARESETN && rvalid && rready) begin
            if (exp_data_q.size() == 0) begin
                stop_run("A read data beat arrived with no read outstanding");
            end
            name = exp_name_q.pop_front();
            check_data(name, exp_data_q.pop_front(), rdata);
            check_resp(name, exp_resp_q.pop_front(), rresp);
            check_id(name, exp_id_q.pop_front(), rid);
            check_last(name, exp_last_q.pop_front(), rlast);
        end
    end

    // ============================================================
    // Stimulus
    // ============================================================
    initial begin : stimulus
        int region;
        void'($urandom(32'h21d7_eae0));
        ARESETN         = 1'b0;
        arvalid         = 1'b0;
        arid            = '0;
        araddr          = '0;
        arlen           = '0;
        arsize          = '0;
        arburst         = '0;
        rready          = 1'b0;
        throttle_rready = 1'b0;
        unmapped_phase  = 1'b0;
        repeat (2) @(posedge ACLK);
        #1;
        ARESETN = 1'b1;
        @(negedge ACLK);
        check_flag("reset rvalid", 1'b0, rvalid);
        check_flag("reset slave arvalid", 1'b0, |m_ar_valid);
        check_flag("reset arready", 1'b1, arready);
        @(posedge ACLK);
        #1;
        for (int reg_i = 0; reg_i < NUM_SLAVES; reg_i++) begin
            for (int len = 0; len < 8; len++) begin
                issue_read($sformatf("mapped region %0d len %0d", reg_i, len),
                           make_addr(reg_i), len_t'(len));
                wait_drained();
            end
        end
        // Regions above the slaves go to the error responder
        unmapped_phase = 1'b1;
        for (int reg_i = NUM_SLAVES; reg_i < 4; reg_i++) begin
            for (int len = 0; len < 8; len++) begin
                issue_read($sformatf("unmapped region %0d len %0d", reg_i, len),
                           make_addr(reg_i), len_t'(len));
                wait_drained();
            end
        end
        unmapped_phase  = 1'b0;
        throttle_rready = 1'b1;
        for (int n = 0; n < 8; n++) begin
            region = $urandom_range(0, 3);
            issue_read($sformatf("throttled read %0d", n), make_addr(region),
                       len_t'($urandom_range(0, 7)));
            wait_drained();
        end
        throttle_rready = 1'b0;
        for (int n = 0; n < 12; n++) begin
            issue_read($sformatf("back-to-back read %0d", n), make_addr(n % 4),
                       len_t'($urandom_range(0, 7)));
        end
        wait_drained();
        // Queue empty, no address or beat left open
        if ((rvalid !== 1'b0) || (m_ar_valid !== '0) || (arready !== 1'b1)) begin
            stop_run("The router was not idle after the last read completed");
        end else begin
            $display("test passed");
            $finish;
        end
    end

endmodule

//--- sim.f
logic/router_pkg.sv
logic/ar_fifo.sv
logic/rd_route_ctrl.sv
logic/ar_demux.sv
logic/r_mux.sv
logic/rd_decerr_slave.sv
logic/axi_rd_router.sv
sim/rd_slave_model.sv
sim/tb_axi_rd_router.sv
